/* logic/cpuPkg.sv */
// shared types for the 6502-subset core; only the listed opcodes decode
// decimal mode, the stack and interrupts do not exist here
`default_nettype none

package cpuPkg;

  // real 6502 encodings of the supported subset
  typedef enum logic [7:0] {
    ldaImm = 8'hA9,
    ldxImm = 8'hA2,
    ldyImm = 8'hA0,
    ldaAbs = 8'hAD,
    staAbs = 8'h8D,
    adcImm = 8'h69,
    sbcImm = 8'hE9,
    andImm = 8'h29,
    oraImm = 8'h09,
    eorImm = 8'h49,
    lsrAcc = 8'h4A,
    taxImp = 8'hAA,
    tayImp = 8'hA8,
    inxImp = 8'hE8,
    inyImp = 8'hC8,
    clcImp = 8'h18,
    secImp = 8'h38,
    beqRel = 8'hF0,
    bneRel = 8'hD0,
    bccRel = 8'h90,
    bcsRel = 8'hB0,
    jmpAbs = 8'h4C,
    nopImp = 8'hEA
  } opcodeE;

  typedef enum logic [3:0] {
    resetLo,
    resetHi,
    t1Fetch,
    t2Operand,
    t3Operand,
    t4Memory,
    branchTake
  } tStateE;

  typedef enum logic [2:0] {
    implied,
    immediate,
    absoluteRead,
    absoluteWrite,
    jump,
    branch
  } addrModeE;

  typedef enum logic [2:0] {
    opSum,
    opSub,
    opAnd,
    opOr,
    opEor,
    opShiftRight,
    opPass
  } aluOpE;

  // status byte bit positions, as on the 6502
  localparam int flagC = 0;
  localparam int flagZ = 1;
  localparam int flagV = 6;
  localparam int flagN = 7;

  // destination register select
  localparam logic [1:0] destNone = 2'd0;
  localparam logic [1:0] destA    = 2'd1;
  localparam logic [1:0] destX    = 2'd2;
  localparam logic [1:0] destY    = 2'd3;

  // flag action
  localparam logic [1:0] flagKeep = 2'd0;
  localparam logic [1:0] flagSetC = 2'd1;
  localparam logic [1:0] flagClrC = 2'd2;
  localparam logic [1:0] flagAlu  = 2'd3;

  localparam logic [15:0] resetVector = 16'hFFFC;

endpackage

`default_nettype wire

/* logic/predecode.sv */
// opcode byte to decoded fields, purely combinational
// unknown bytes run as a two-cycle NOP
`default_nettype none

module predecode (
  input  logic [7:0]       dataIn,
  output cpuPkg::opcodeE   opcode,
  output cpuPkg::addrModeE addrMode,
  output cpuPkg::aluOpE    aluOp,
  output logic [1:0]       destSel,
  output logic [1:0]       flagAct
);
  import cpuPkg::*;

  always_comb begin
    opcode   = opcodeE'(dataIn);
    addrMode = implied;
    aluOp    = opPass;
    destSel  = destNone;
    flagAct  = flagKeep;
    case (dataIn)
      ldaImm: begin addrMode = immediate; destSel = destA; end
      ldxImm: begin addrMode = immediate; destSel = destX; end
      ldyImm: begin addrMode = immediate; destSel = destY; end
      ldaAbs: begin addrMode = absoluteRead; destSel = destA; end
      staAbs: addrMode = absoluteWrite;
      adcImm: begin addrMode = immediate; aluOp = opSum; destSel = destA; flagAct = flagAlu; end
      sbcImm: begin addrMode = immediate; aluOp = opSub; destSel = destA; flagAct = flagAlu; end
      andImm: begin addrMode = immediate; aluOp = opAnd; destSel = destA; end
      oraImm: begin addrMode = immediate; aluOp = opOr; destSel = destA; end
      eorImm: begin addrMode = immediate; aluOp = opEor; destSel = destA; end
      lsrAcc: begin aluOp = opShiftRight; destSel = destA; flagAct = flagAlu; end
      // transfers are A or zero, the operand byte is cleared for implied ops
      taxImp: begin aluOp = opOr; destSel = destX; end
      tayImp: begin aluOp = opOr; destSel = destY; end
      // index plus zero with a forced carry in
      inxImp: begin aluOp = opSum; destSel = destX; end
      inyImp: begin aluOp = opSum; destSel = destY; end
      clcImp: flagAct = flagClrC;
      secImp: flagAct = flagSetC;
      beqRel, bneRel, bccRel, bcsRel: addrMode = branch;
      jmpAbs: addrMode = jump;
      nopImp: addrMode = implied;
      default: opcode = nopImp;
    endcase
  end

endmodule

`default_nettype wire

/* logic/instructionRegister.sv */
// decoded instruction and operand bytes, held while rdy is low
`default_nettype none

module instructionRegister (
  input  logic             phi2,
  input  logic             rst,
  input  logic             rdy,
  input  logic             loadOpcode,
  input  logic             loadLo,
  input  logic             loadHi,
  input  cpuPkg::opcodeE   opcodeIn,
  input  cpuPkg::addrModeE addrModeIn,
  input  cpuPkg::aluOpE    aluOpIn,
  input  logic [1:0]       destSelIn,
  input  logic [1:0]       flagActIn,
  input  logic [7:0]       dataIn,
  output cpuPkg::opcodeE   opcode,
  output cpuPkg::addrModeE addrMode,
  output cpuPkg::aluOpE    aluOp,
  output logic [1:0]       destSel,
  output logic [1:0]       flagAct,
  output logic [7:0]       operandLo,
  output logic [7:0]       operandHi
);
  import cpuPkg::*;

  always_ff @(posedge phi2) begin
    if (rst) begin
      opcode   <= nopImp;
      addrMode <= implied;
      aluOp    <= opPass;
      destSel  <= destNone;
      flagAct  <= flagKeep;
    end else if (rdy && loadOpcode) begin
      opcode   <= opcodeIn;
      addrMode <= addrModeIn;
      aluOp    <= aluOpIn;
      destSel  <= destSelIn;
      flagAct  <= flagActIn;
    end
  end

  always_ff @(posedge phi2) begin
    if (rdy) begin
      // implied ops see a zero operand
      if (loadOpcode) begin
        operandLo <= 8'h00;
      end else if (loadLo) begin
        operandLo <= dataIn;
      end
      if (loadHi) begin
        operandHi <= dataIn;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/programCounter.sv */
// 16-bit program counter; branch offset is relative to the next opcode
`default_nettype none

module programCounter (
  input  logic        phi2,
  input  logic        rst,
  input  logic        rdy,
  input  logic        incPc,
  input  logic        loadVecLo,
  input  logic        loadVecHi,
  input  logic        loadJump,
  input  logic        loadBranch,
  input  logic [7:0]  dataIn,
  input  logic [7:0]  operandLo,
  output logic [15:0] pc
);

  always_ff @(posedge phi2) begin
    if (rst) begin
      pc <= 16'h0000;
    end else if (rdy) begin
      if (loadVecLo) begin
        pc[7:0] <= dataIn;
      end else if (loadVecHi) begin
        pc[15:8] <= dataIn;
      end else if (loadJump) begin
        // high byte is on the bus in the jump's third cycle
        pc <= {dataIn, operandLo};
      end else if (loadBranch) begin
        pc <= pc + {{8{operandLo[7]}}, operandLo};
      end else if (incPc) begin
        pc <= pc + 16'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/timingControl.sv */
// T-state sequencer; one instruction in flight, no page-cross penalty
// write cycles finish regardless of rdy, read cycles stretch while rdy is low
`default_nettype none

module timingControl (
  input  logic             phi2,
  input  logic             rst,
  input  logic             rdy,
  input  cpuPkg::addrModeE addrMode,
  input  cpuPkg::opcodeE   opcode,
  input  logic [7:0]       flags,
  input  logic [15:0]      pc,
  input  logic [7:0]       operandLo,
  input  logic [7:0]       operandHi,
  output logic [15:0]      addr,
  output logic             rw,
  output logic             sync,
  output logic             loadOpcode,
  output logic             loadLo,
  output logic             loadHi,
  output logic             incPc,
  output logic             loadVecLo,
  output logic             loadVecHi,
  output logic             loadJump,
  output logic             loadBranch,
  output logic             writeReg,
  output logic             writeFlags,
  output logic             useMemData
);
  import cpuPkg::*;

  tStateE state;
  tStateE nextState;
  logic   taken;
  logic   advance;

  always_comb begin
    case (opcode)
      beqRel:  taken = flags[flagZ];
      bneRel:  taken = !flags[flagZ];
      bccRel:  taken = !flags[flagC];
      bcsRel:  taken = flags[flagC];
      default: taken = 1'b0;
    endcase
  end

  assign advance = rdy || !rw;

  always_ff @(posedge phi2) begin
    if (rst) begin
      state <= resetLo;
    end else if (advance) begin
      state <= nextState;
    end
  end

  always_comb begin
    addr       = pc;
    rw         = 1'b1;
    sync       = 1'b0;
    loadOpcode = 1'b0;
    loadLo     = 1'b0;
    loadHi     = 1'b0;
    incPc      = 1'b0;
    loadVecLo  = 1'b0;
    loadVecHi  = 1'b0;
    loadJump   = 1'b0;
    loadBranch = 1'b0;
    writeReg   = 1'b0;
    writeFlags = 1'b0;
    useMemData = 1'b0;
    nextState  = state;
    case (state)
      resetLo: begin
        addr      = resetVector;
        loadVecLo = 1'b1;
        nextState = resetHi;
      end
      resetHi: begin
        addr      = resetVector + 16'd1;
        loadVecHi = 1'b1;
        nextState = t1Fetch;
      end
      t1Fetch: begin
        sync       = 1'b1;
        loadOpcode = 1'b1;
        incPc      = 1'b1;
        nextState  = t2Operand;
      end
      t2Operand: begin
        case (addrMode)
          // dummy read of the next opcode, pc stays
          implied: begin
            writeReg   = 1'b1;
            writeFlags = 1'b1;
            nextState  = t1Fetch;
          end
          immediate: begin
            incPc      = 1'b1;
            writeReg   = 1'b1;
            writeFlags = 1'b1;
            useMemData = 1'b1;
            nextState  = t1Fetch;
          end
          branch: begin
            incPc     = 1'b1;
            loadLo    = 1'b1;
            nextState = taken ? branchTake : t1Fetch;
          end
          default: begin
            incPc     = 1'b1;
            loadLo    = 1'b1;
            nextState = t3Operand;
          end
        endcase
      end
      t3Operand: begin
        if (addrMode == jump) begin
          loadJump  = 1'b1;
          nextState = t1Fetch;
        end else begin
          incPc     = 1'b1;
          loadHi    = 1'b1;
          nextState = t4Memory;
        end
      end
      t4Memory: begin
        addr = {operandHi, operandLo};
        if (addrMode == absoluteWrite) begin
          rw = 1'b0;
        end else begin
          writeReg   = 1'b1;
          writeFlags = 1'b1;
          useMemData = 1'b1;
        end
        nextState = t1Fetch;
      end
      branchTake: begin
        loadBranch = 1'b1;
        nextState  = t1Fetch;
      end
      default: nextState = resetLo;
    endcase
  end

endmodule

`default_nettype wire

/* logic/alu.sv */
// 8-bit binary ALU, no decimal mode
`default_nettype none

module alu (
  input  cpuPkg::aluOpE aluOp,
  input  logic [7:0]    a,
  input  logic [7:0]    b,
  input  logic          carryIn,
  output logic [7:0]    result,
  output logic          carryOut,
  output logic          overflow
);
  import cpuPkg::*;

  logic [7:0] bEff;
  logic [8:0] sum;

  always_comb begin
    // subtract is a plus not b plus carry, so carry set means no borrow
    bEff     = (aluOp == opSub) ? ~b : b;
    sum      = {1'b0, a} + {1'b0, bEff} + {8'h00, carryIn};
    result   = b;
    carryOut = 1'b0;
    overflow = 1'b0;
    case (aluOp)
      opSum, opSub: begin
        result   = sum[7:0];
        carryOut = sum[8];
        // both inputs agree in sign, result does not
        overflow = (a[7] == bEff[7]) && (sum[7] != a[7]);
      end
      opAnd: begin
        result = a & b;
      end
      opOr: begin
        result = a | b;
      end
      opEor: begin
        result = a ^ b;
      end
      opShiftRight: begin
        result   = {1'b0, a[7:1]};
        carryOut = a[0];
      end
      default: begin
        result = b;
      end
    endcase
  end

endmodule

`default_nettype wire

/* logic/registerFile.sv */
// A, X, Y and the C, Z, V, N flags; other status bits read as zero
`default_nettype none

module registerFile (
  input  logic          phi2,
  input  logic          rst,
  input  logic          rdy,
  input  logic          writeReg,
  input  logic          writeFlags,
  input  logic [1:0]    destSel,
  input  logic [1:0]    flagAct,
  input  cpuPkg::aluOpE aluOp,
  input  logic [7:0]    result,
  input  logic          carryOut,
  input  logic          overflow,
  output logic [7:0]    regA,
  output logic [7:0]    regX,
  output logic [7:0]    regY,
  output logic [7:0]    flags
);
  import cpuPkg::*;

  logic [7:0] status;

  assign flags = status;

  always_ff @(posedge phi2) begin
    if (rst) begin
      regA   <= 8'h00;
      regX   <= 8'h00;
      regY   <= 8'h00;
      status <= 8'h00;
    end else if (rdy) begin
      if (writeReg && destSel != destNone) begin
        case (destSel)
          destA:   regA <= result;
          destX:   regX <= result;
          default: regY <= result;
        endcase
        status[flagZ] <= (result == 8'h00);
        status[flagN] <= result[7];
      end
      if (writeFlags) begin
        case (flagAct)
          flagSetC: status[flagC] <= 1'b1;
          flagClrC: status[flagC] <= 1'b0;
          flagAlu: begin
            status[flagC] <= carryOut;
            // shift leaves V alone
            if (aluOp == opSum || aluOp == opSub) begin
              status[flagV] <= overflow;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* logic/cpuCore.sv */
// 6502-subset core on the 6502 bus; single clock phi2, no IRQ or NMI
// dataIn must be valid in the same cycle as the read address
`default_nettype none

module cpuCore (
  input  logic        phi2,
  input  logic        rst,
  input  logic        rdy,
  input  logic [7:0]  dataIn,
  output logic [15:0] addr,
  output logic [7:0]  dataOut,
  output logic        rw,
  output logic        sync
);
  import cpuPkg::*;

  // predecoded fields
  opcodeE     pdOpcode;
  addrModeE   pdAddrMode;
  aluOpE      pdAluOp;
  logic [1:0] pdDestSel;
  logic [1:0] pdFlagAct;

  // current instruction
  opcodeE     irOpcode;
  addrModeE   irAddrMode;
  aluOpE      irAluOp;
  logic [1:0] irDestSel;
  logic [1:0] irFlagAct;
  logic [7:0] operandLo;
  logic [7:0] operandHi;

  logic [15:0] pc;
  logic loadOpcode, loadLo, loadHi, incPc, loadVecLo, loadVecHi;
  logic loadJump, loadBranch, writeReg, writeFlags, useMemData;

  logic [7:0] regA, regX, regY, flags;
  logic [7:0] result;
  logic       carryOut, overflow;

  // alu operand select, INX and INY add a forced carry to the index
  wire       incX = (irOpcode == inxImp);
  wire       incY = (irOpcode == inyImp);
  wire [7:0] aluA = incX ? regX : (incY ? regY : regA);
  wire [7:0] aluB = useMemData ? dataIn : operandLo;
  wire       aluCarryIn = incX || incY || flags[flagC];

  assign dataOut = regA;

  predecode u_predecode (
    .dataIn(dataIn), .opcode(pdOpcode), .addrMode(pdAddrMode),
    .aluOp(pdAluOp), .destSel(pdDestSel), .flagAct(pdFlagAct)
  );

  instructionRegister u_instructionRegister (
    .phi2(phi2), .rst(rst), .rdy(rdy),
    .loadOpcode(loadOpcode), .loadLo(loadLo), .loadHi(loadHi),
    .opcodeIn(pdOpcode), .addrModeIn(pdAddrMode), .aluOpIn(pdAluOp),
    .destSelIn(pdDestSel), .flagActIn(pdFlagAct), .dataIn(dataIn),
    .opcode(irOpcode), .addrMode(irAddrMode), .aluOp(irAluOp),
    .destSel(irDestSel), .flagAct(irFlagAct),
    .operandLo(operandLo), .operandHi(operandHi)
  );

  programCounter u_programCounter (
    .phi2(phi2), .rst(rst), .rdy(rdy), .incPc(incPc),
    .loadVecLo(loadVecLo), .loadVecHi(loadVecHi),
    .loadJump(loadJump), .loadBranch(loadBranch),
    .dataIn(dataIn), .operandLo(operandLo), .pc(pc)
  );

  timingControl u_timingControl (
    .phi2(phi2), .rst(rst), .rdy(rdy),
    .addrMode(irAddrMode), .opcode(irOpcode), .flags(flags), .pc(pc),
    .operandLo(operandLo), .operandHi(operandHi),
    .addr(addr), .rw(rw), .sync(sync),
    .loadOpcode(loadOpcode), .loadLo(loadLo), .loadHi(loadHi), .incPc(incPc),
    .loadVecLo(loadVecLo), .loadVecHi(loadVecHi),
    .loadJump(loadJump), .loadBranch(loadBranch),
    .writeReg(writeReg), .writeFlags(writeFlags), .useMemData(useMemData)
  );

  alu u_alu (
    .aluOp(irAluOp), .a(aluA), .b(aluB), .carryIn(aluCarryIn),
    .result(result), .carryOut(carryOut), .overflow(overflow)
  );

  registerFile u_registerFile (
    .phi2(phi2), .rst(rst), .rdy(rdy),
    .writeReg(writeReg), .writeFlags(writeFlags),
    .destSel(irDestSel), .flagAct(irFlagAct), .aluOp(irAluOp),
    .result(result), .carryOut(carryOut), .overflow(overflow),
    .regA(regA), .regX(regX), .regY(regY), .flags(flags)
  );

endmodule

`default_nettype wire

/* bench/cpuChecker.sv */
// watches the cpuCore bus and compares writes with the expected list
// a high rst restarts the list, the first-sync check and the cycle count
`default_nettype none

module cpuChecker (
  input  logic        phi2,
  input  logic        rst,
  input  logic [15:0] addr,
  input  logic [7:0]  dataOut,
  input  logic        rw,
  input  logic        sync,
  input  int          testId,
  input  logic [15:0] expAddr [0:255],
  input  logic [7:0]  expData [0:255],
  input  int          expCount,
  input  logic [15:0] startAddr,
  input  logic [15:0] finalAddr,
  input  int          cycleLimit,
  output logic        done,
  output logic        timedOut,
  output int          errorCount,
  output int          writesChecked
);

  int   idx;
  int   cycles;
  logic seenSync;

  function automatic string testName(input int id);
    case (id)
      0: return "loadsTransfers";
      1: return "aluCarry";
      2: return "absCopy";
      3: return "branches";
      4: return "randomStalls";
      5: return "noStalls";
      default: return "midReset";
    endcase
  endfunction

  initial begin
    errorCount = 0;
    writesChecked = 0;
    done = 1'b0;
    timedOut = 1'b0;
    idx = 0;
    cycles = 0;
    seenSync = 1'b0;
  end

  always @(posedge phi2) begin
    if (rst) begin
      idx <= 0;
      cycles <= 0;
      seenSync <= 1'b0;
      done <= 1'b0;
      timedOut <= 1'b0;
    end else if (!done && !timedOut) begin
      cycles <= cycles + 1;
      if (cycles >= cycleLimit) begin
        $display("%s: timeout, no final jump within %0d cycles", testName(testId), cycleLimit);
        timedOut <= 1'b1;
      end
      if (!rw) begin
        writesChecked <= writesChecked + 1;
        if (idx >= expCount) begin
          $display("%s: unexpected write of %02h to %04h", testName(testId), dataOut, addr);
          errorCount <= errorCount + 1;
        end else if (addr != expAddr[idx[7:0]] || dataOut != expData[idx[7:0]]) begin
          $display("[ERROR] %s: write %0d expected %04h=%02h actual %04h=%02h",
                   testName(testId), idx, expAddr[idx[7:0]], expData[idx[7:0]],
                   addr, dataOut);
          errorCount <= errorCount + 1;
        end
        idx <= idx + 1;
      end else if (sync && !seenSync) begin
        // first fetch after reset comes from the vector
        seenSync <= 1'b1;
        if (addr != startAddr) begin
          $display("[ERROR] %s: first fetch expected %04h actual %04h",
                   testName(testId), startAddr, addr);
          errorCount <= errorCount + 1;
        end
      end else if (sync && addr == finalAddr) begin
        done <= 1'b1;
        if (idx < expCount) begin
          $display("%s: final jump reached after %0d of %0d writes",
                   testName(testId), idx, expCount);
          errorCount <= errorCount + 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* bench/cpuTb.sv */
// random subset programs against cpuCore with rdy stalls and a mid-run reset
// programs start at 0x80xx and write page 0x02 and read page 0x03
`default_nettype none

module cpuTb;

  logic        phi2;
  logic        rst;
  logic        rdy;
  logic [7:0]  dataIn;
  logic [15:0] addr;
  logic [7:0]  dataOut;
  logic        rw;
  logic        sync;

  logic [7:0]  mem [0:65535];
  logic [15:0] expAddr [0:255];
  logic [7:0]  expData [0:255];
  int          expCount;
  int          testId;
  int          nInstr;
  int          cycleLimit;
  logic [15:0] startAddr;
  logic [15:0] finalAddr;
  logic        stallEnable;
  logic [31:0] genState;
  logic [31:0] stallState;
  logic        done;
  logic        timedOut;
  int          errorCount;
  int          writesChecked;
  int          testsRun;
  logic        aborted;

  cpuCore u_cpuCore (
    .phi2(phi2), .rst(rst), .rdy(rdy), .dataIn(dataIn),
    .addr(addr), .dataOut(dataOut), .rw(rw), .sync(sync)
  );

  cpuChecker u_cpuChecker (
    .phi2(phi2), .rst(rst), .addr(addr), .dataOut(dataOut), .rw(rw), .sync(sync),
    .testId(testId), .expAddr(expAddr), .expData(expData), .expCount(expCount),
    .startAddr(startAddr), .finalAddr(finalAddr), .cycleLimit(cycleLimit),
    .done(done), .timedOut(timedOut), .errorCount(errorCount),
    .writesChecked(writesChecked)
  );

  initial begin
    phi2 = 1'b0;
    forever #5 phi2 = ~phi2;
  end

  // memory model with read data valid in the same cycle as the address
  assign dataIn = mem[addr];

  always @(posedge phi2) begin
    if (!rw) begin
      mem[addr] <= dataOut;
    end
  end

  // rdy only drops on read cycles
  always @(posedge phi2) begin
    #1;
    stallState = xorshift(stallState);
    rdy = !(stallEnable && rw && stallState[1:0] == 2'b00);
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [7:0] nextByte();
    genState = xorshift(genState);
    return genState[15:8];
  endfunction

  task automatic putByte(inout logic [15:0] p, input logic [7:0] b);
    mem[p] = b;
    p = p + 16'd1;
  endtask

  task automatic putImmediate(inout logic [15:0] p, input logic [7:0] op);
    putByte(p, op);
    putByte(p, nextByte());
  endtask

  task automatic putStore(inout logic [15:0] p);
    putByte(p, 8'h8D);
    putByte(p, nextByte());
    putByte(p, 8'h02);
  endtask

  // instruction kind per test, see the case in buildProgram
  function automatic int pickKind(input int test, input logic [7:0] r);
    int loadKinds [9];
    int carryKinds [10];
    int branchKinds [6];
    // branches make the Z flag of X and Y results visible
    loadKinds = '{0, 1, 2, 3, 4, 5, 6, 7, 17};
    carryKinds = '{7, 8, 9, 10, 11, 12, 13, 14, 15, 17};
    branchKinds = '{0, 7, 14, 15, 17, 11};
    case (test)
      0: return loadKinds[r % 9];
      1: return carryKinds[r % 10];
      2: return r[0] ? 16 : 7;
      3: return branchKinds[r % 6];
      default: return int'(r % 19);
    endcase
  endfunction

  task automatic buildProgram(input int test);
    logic [15:0] p;
    logic [7:0]  r;
    int          kind;
    logic [7:0]  brOps [4];
    brOps = '{8'hF0, 8'hD0, 8'h90, 8'hB0};
    for (int i = 0; i < 256; i++) begin
      mem[16'h0300 + i[15:0]] = nextByte();
    end
    r = nextByte();
    startAddr = 16'h8000 + {8'h00, r};
    mem[16'hFFFC] = startAddr[7:0];
    mem[16'hFFFD] = startAddr[15:8];
    p = startAddr;
    nInstr = 0;
    for (int i = 0; i < 30; i++) begin
      r = nextByte();
      kind = pickKind(test, r);
      nInstr++;
      case (kind)
        0: begin
          putByte(p, 8'hA9);
          putByte(p, r[3] ? 8'h00 : nextByte());
        end
        1: putImmediate(p, 8'hA2);
        2: putImmediate(p, 8'hA0);
        3: putByte(p, 8'hAA);
        4: putByte(p, 8'hA8);
        5: putByte(p, 8'hE8);
        6: putByte(p, 8'hC8);
        7: putStore(p);
        8: putImmediate(p, 8'h69);
        9: putImmediate(p, 8'hE9);
        10: putImmediate(p, 8'h29);
        11: putImmediate(p, 8'h09);
        12: putImmediate(p, 8'h49);
        13: putByte(p, 8'h4A);
        14: putByte(p, 8'h18);
        15: putByte(p, 8'h38);
        16: begin
          putByte(p, 8'hAD);
          putByte(p, nextByte());
          putByte(p, 8'h03);
        end
        17: begin
          // forward branch over exactly one store
          putByte(p, (test == 1) ? brOps[2 + int'(r[4])] : brOps[r[5:4]]);
          putByte(p, 8'h03);
          putStore(p);
          nInstr++;
        end
        default: putByte(p, 8'hEA);
      endcase
      if (kind != 7 && kind != 17 && r[6]) begin
        putStore(p);
        nInstr++;
      end
    end
    finalAddr = p;
    putByte(p, 8'h4C);
    putByte(p, finalAddr[7:0]);
    putByte(p, finalAddr[15:8]);
    nInstr++;
    cycleLimit = 8 * nInstr * 2 + 100;
  endtask

  // 6502 model over the memory image that fills the expected write list
  function automatic int referenceWrites(input logic [15:0] start, input logic [15:0] stopAt);
    logic [15:0] pc;
    logic [7:0]  a;
    logic [7:0]  x;
    logic [7:0]  y;
    logic [7:0]  op;
    logic [7:0]  lo;
    logic [7:0]  hi;
    logic [7:0]  res;
    logic        c;
    logic        z;
    logic        taken;
    logic        touchZ;
    logic [8:0]  s;
    int          d;
    int          len;
    int          cnt;
    int          steps;
    pc = start;
    a = 8'h00;
    x = 8'h00;
    y = 8'h00;
    res = 8'h00;
    c = 1'b0;
    z = 1'b0;
    cnt = 0;
    steps = 0;
    while (pc != stopAt && steps < 1000) begin
      op = mem[pc];
      lo = mem[pc + 16'd1];
      hi = mem[pc + 16'd2];
      steps++;
      len = 1;
      touchZ = 1'b1;
      case (op)
        8'hA9: begin
          a = lo;
          res = a;
          len = 2;
        end
        8'hA2: begin
          x = lo;
          res = x;
          len = 2;
        end
        8'hA0: begin
          y = lo;
          res = y;
          len = 2;
        end
        8'hAD: begin
          a = mem[{hi, lo}];
          res = a;
          len = 3;
        end
        8'h8D: begin
          expAddr[cnt[7:0]] = {hi, lo};
          expData[cnt[7:0]] = a;
          cnt++;
          touchZ = 1'b0;
          len = 3;
        end
        8'h69: begin
          s = {1'b0, a} + {1'b0, lo} + {8'h00, c};
          a = s[7:0];
          c = s[8];
          res = a;
          len = 2;
        end
        8'hE9: begin
          // a clear carry borrows one more
          d = int'(a) - int'(lo) - int'(!c);
          c = (d >= 0);
          a = d[7:0];
          res = a;
          len = 2;
        end
        8'h29: begin
          a = a & lo;
          res = a;
          len = 2;
        end
        8'h09: begin
          a = a | lo;
          res = a;
          len = 2;
        end
        8'h49: begin
          a = a ^ lo;
          res = a;
          len = 2;
        end
        8'h4A: begin
          c = a[0];
          a = a >> 1;
          res = a;
        end
        8'hAA: begin
          x = a;
          res = x;
        end
        8'hA8: begin
          y = a;
          res = y;
        end
        8'hE8: begin
          x = x + 8'd1;
          res = x;
        end
        8'hC8: begin
          y = y + 8'd1;
          res = y;
        end
        8'h18: begin
          c = 1'b0;
          touchZ = 1'b0;
        end
        8'h38: begin
          c = 1'b1;
          touchZ = 1'b0;
        end
        8'hF0, 8'hD0, 8'h90, 8'hB0: begin
          case (op)
            8'hF0: taken = z;
            8'hD0: taken = !z;
            8'h90: taken = !c;
            default: taken = c;
          endcase
          touchZ = 1'b0;
          len = taken ? 2 + int'(signed'(lo)) : 2;
        end
        8'h4C: begin
          pc = {hi, lo};
          touchZ = 1'b0;
          len = 0;
        end
        default: touchZ = 1'b0;
      endcase
      if (touchZ) begin
        z = (res == 8'h00);
      end
      pc = pc + len[15:0];
    end
    return cnt;
  endfunction

  task automatic runTest(input int test);
    @(posedge phi2);
    #1;
    rst = 1'b1;
    testId = test;
    @(posedge phi2);
    @(posedge phi2);
    #1;
    // the no-stall run repeats the previous program
    if (test != 5) begin
      buildProgram(test);
      expCount = referenceWrites(startAddr, finalAddr);
    end
    stallEnable = (test != 5);
    rst = 1'b0;
    if (test == 6) begin
      repeat (60) @(posedge phi2);
      #1;
      rst = 1'b1;
      @(posedge phi2);
      @(posedge phi2);
      #1;
      rst = 1'b0;
    end
    while (!done && !timedOut) begin
      @(posedge phi2);
    end
    #1;
  endtask

  initial begin
    rst = 1'b1;
    rdy = 1'b1;
    stallEnable = 1'b1;
    testId = 0;
    expCount = 0;
    nInstr = 0;
    cycleLimit = 1000;
    startAddr = 16'h8000;
    finalAddr = 16'h8000;
    genState = 32'd71904;
    stallState = xorshift(32'd71904);
    testsRun = 0;
    aborted = 1'b0;
    for (int i = 0; i < 65536; i++) begin
      mem[i[15:0]] = i[7:0] ^ i[15:8] ^ 8'h5A;
    end
    while (testsRun < 7 && !aborted) begin
      runTest(testsRun);
      testsRun++;
      aborted = timedOut;
    end
    $display("tests run %0d, writes checked %0d, errors %0d",
             testsRun, writesChecked, errorCount + (aborted ? 1 : 0));
    if (errorCount == 0 && !aborted) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
logic/cpuPkg.sv
logic/predecode.sv
logic/instructionRegister.sv
logic/programCounter.sv
logic/timingControl.sv
logic/alu.sv
logic/registerFile.sv
logic/cpuCore.sv
bench/cpuChecker.sv
bench/cpuTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the cpuCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module cpuTb -f filelist.f \
  --Mdir build -o cpuSim > build.log 2>&1 \
  && ./build/cpuSim > sim.log 2>&1 \
  || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "CHECKS FAILED" sim.log && { echo "FAIL"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log && { echo "PASS"; exit 0; } \
  || { echo "FAIL: no result line"; exit 1; }
